// File: design/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6

// idle cycles between memory address and data, valid 1..7
`define MEM_WAIT_CYCLES 2
`define WAIT_CNT_W      3

`endif

// File: design/ctrlPkg.sv
`include "ctrl_config.svh"

package ctrlPkg;

    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`FUNCT_W-1:0]    funct_t;
    typedef logic [`WAIT_CNT_W-1:0] waitCnt_t;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } instrFields_t;

    typedef struct packed {
        logic overflow;
        logic zero;
        logic equal;
    } aluFlags_t;

    // opcodes
    localparam opcode_t rType = 6'h00;
    localparam opcode_t j     = 6'h02;
    localparam opcode_t jal   = 6'h03;
    localparam opcode_t beq   = 6'h04;
    localparam opcode_t bne   = 6'h05;
    localparam opcode_t addi  = 6'h08;
    localparam opcode_t addiu = 6'h09;
    localparam opcode_t slti  = 6'h0a;
    localparam opcode_t lui   = 6'h0f;
    localparam opcode_t lw    = 6'h23;
    localparam opcode_t sw    = 6'h2b;

    // funct codes, opcode 0 only
    localparam funct_t jrOp  = 6'h08;
    localparam funct_t addOp = 6'h20;
    localparam funct_t subOp = 6'h22;
    localparam funct_t andOp = 6'h24;
    localparam funct_t sltOp = 6'h2a;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsAluImmNoOvf, clsSltImm, clsLui, clsJr, clsLoad,
        clsStore, clsBranchEq, clsBranchNe, clsJump, clsJumpLink, clsIllegal
    } instrClass_t;

    typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluCompare} aluOp_t;

    typedef enum logic [4:0] {
        fetch1, fetch2, fetch3, decode1, decode2, execute,
        aluToRd, aluToRt,
        memAddr, memWait, loadWrite, storeWrite,
        branchResolve, jalLink, jalJump,
        excSave, excVector, excWait, excJump,
        finish
    } ctrlState_t;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstSel_t;
    typedef enum logic [1:0] {wbAluOut, wbMemData, wbCompare, wbUpperImm} memToRegSel_t;
    typedef enum logic [1:0] {pcAluResult, pcBranchTarget, pcJumpTarget, pcExcHandler} pcSrcSel_t;
    typedef enum logic [1:0] {addrPc, addrAluOut, addrVecIllegal, addrVecOverflow} iorDSel_t;
    typedef enum logic {srcAPc, srcARegA} aluSrcASel_t;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm} aluSrcBSel_t;

    typedef struct packed {
        logic memWrite;
        logic pcWrite;
        logic irWrite;
        logic regWrite;
        logic abWrite;
        logic aluOutWrite;
        logic epcWrite;
    } writeEnables_t;

    typedef struct packed {
        writeEnables_t we;
        aluOp_t        aluOp;
        regDstSel_t    regDst;
        memToRegSel_t  memToReg;
        pcSrcSel_t     pcSrc;
        iorDSel_t      iorD;
        aluSrcASel_t   aluSrcA;
        aluSrcBSel_t   aluSrcB;
    } ctrlWord_t;

    // classes whose result is dropped on overflow
    function automatic logic ovfChecked(instrClass_t cls);
        return (cls == clsAluReg) || (cls == clsAluImm);
    endfunction

endpackage

// File: design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  ctrlPkg::instrFields_t instr,
    output ctrlPkg::instrClass_t  instrClass,
    output ctrlPkg::aluOp_t       aluOp
);
    import ctrlPkg::*;

    always_comb begin
        case (instr.opcode)
            rType: begin
                case (instr.funct)
                    addOp, subOp, andOp, sltOp: instrClass = clsAluReg;
                    jrOp:                       instrClass = clsJr;
                    default:                    instrClass = clsIllegal;
                endcase
            end
            addi:    instrClass = clsAluImm;
            addiu:   instrClass = clsAluImmNoOvf;
            slti:    instrClass = clsSltImm;
            lui:     instrClass = clsLui;
            lw:      instrClass = clsLoad;
            sw:      instrClass = clsStore;
            beq:     instrClass = clsBranchEq;
            bne:     instrClass = clsBranchNe;
            j:       instrClass = clsJump;
            jal:     instrClass = clsJumpLink;
            default: instrClass = clsIllegal;
        endcase
    end

    // alu operation follows the class, funct only matters for R-type
    always_comb begin
        case (instrClass)
            clsAluReg: begin
                case (instr.funct)
                    addOp:   aluOp = aluAdd;
                    subOp:   aluOp = aluSub;
                    andOp:   aluOp = aluAnd;
                    default: aluOp = aluCompare; // slt
                endcase
            end
            clsAluImm, clsAluImmNoOvf, clsLoad, clsStore: aluOp = aluAdd;
            clsSltImm, clsBranchEq, clsBranchNe:          aluOp = aluCompare;
            default:                                      aluOp = aluPass;
        endcase
    end

    // a known instruction must never decode to X
    always_comb begin
        if (!$isunknown(instr)) begin
            assert (!$isunknown({instrClass, aluOp}))
                else $error("instrDecoder: unknown output for opcode %h", instr.opcode);
        end
    end

endmodule

// File: design/controlFsm.sv
`timescale 1ns/1ps
`include "ctrl_config.svh"

module controlFsm (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::instrClass_t instrClass,
    input  ctrlPkg::aluFlags_t   flags,
    output ctrlPkg::ctrlState_t  state,
    output ctrlPkg::instrClass_t latchedClass
);
    import ctrlPkg::*;

    localparam waitCnt_t lastWait = waitCnt_t'(`MEM_WAIT_CYCLES - 1);

    ctrlState_t  nextState;
    instrClass_t classQ;
    waitCnt_t    waitCnt;
    logic        inWait;
    logic        waitDone;

    assign inWait   = (state == memWait) || (state == excWait);
    assign waitDone = (waitCnt == lastWait);

    // live decode during execute, held copy after that
    assign latchedClass = (state == execute) ? instrClass : classQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fetch1;
            classQ  <= clsIllegal;
            waitCnt <= '0;
        end else begin
            state <= nextState;
            if (state == execute) begin
                classQ <= instrClass;
            end
            waitCnt <= (inWait && !waitDone) ? waitCnt + 1'b1 : '0; // shared by mem and exc waits
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            fetch1:  nextState = fetch2;
            fetch2:  nextState = fetch3;
            fetch3:  nextState = decode1;
            decode1: nextState = decode2;
            decode2: nextState = execute;
            execute: begin
                case (instrClass)
                    clsAluReg:                 nextState = aluToRd;
                    clsAluImm, clsAluImmNoOvf: nextState = aluToRt;
                    clsLoad, clsStore:         nextState = memAddr;
                    clsBranchEq, clsBranchNe:  nextState = branchResolve;
                    clsJumpLink:               nextState = jalLink;
                    clsIllegal:                nextState = excSave;
                    default:                   nextState = finish; // done in execute
                endcase
            end
            aluToRd, aluToRt: begin
                if (flags.overflow && ovfChecked(classQ)) begin
                    nextState = excSave;
                end else begin
                    nextState = finish;
                end
            end
            memAddr: nextState = memWait;
            memWait: begin
                if (waitDone) begin
                    nextState = (classQ == clsStore) ? storeWrite : loadWrite;
                end
            end
            jalLink:   nextState = jalJump;
            excSave:   nextState = excVector;
            excVector: nextState = excWait;
            excWait: begin
                if (waitDone) begin
                    nextState = excJump;
                end
            end
            loadWrite, storeWrite, branchResolve, jalJump, excJump: nextState = finish;
            default: nextState = fetch1;
        endcase
    end

    // memory access takes exactly N idle cycles, then the write state
    property memWaitBounded;
        @(posedge clk) disable iff (reset)
            (state == memAddr) |=> (state == memWait) [*`MEM_WAIT_CYCLES]
                ##1 (state inside {loadWrite, storeWrite});
    endproperty
    assert property (memWaitBounded)
        else $error("controlFsm: memWait length differs from MEM_WAIT_CYCLES");

    assert property (@(posedge clk) disable iff (reset) (state == finish) |=> (state == fetch1))
        else $error("controlFsm: finish not followed by fetch1");

endmodule

// File: design/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::ctrlState_t  state,
    input  ctrlPkg::instrClass_t latchedClass,
    input  ctrlPkg::aluOp_t      aluOp,
    input  ctrlPkg::aluFlags_t   flags,
    output ctrlPkg::ctrlWord_t   ctrl
);
    import ctrlPkg::*;

    aluOp_t   aluOpQ;
    logic     branchTaken;
    logic     ovfTrap;
    iorDSel_t excVec;

    // R-type op replayed in aluToRd
    always_ff @(posedge clk) begin
        if (state == execute) begin
            aluOpQ <= aluOp;
        end
    end

    assign branchTaken = (latchedClass == clsBranchEq) ? flags.equal : !flags.equal;
    assign ovfTrap     = flags.overflow && ovfChecked(latchedClass);
    assign excVec      = (latchedClass == clsIllegal) ? addrVecIllegal : addrVecOverflow;

    always_comb begin
        ctrl = '0;
        case (state)
            fetch1, fetch2: begin // read at pc, pc + 4 on the alu
                ctrl.aluSrcA    = srcAPc;
                ctrl.aluSrcB    = srcBFour;
                ctrl.aluOp      = aluAdd;
                ctrl.we.pcWrite = (state == fetch2);
            end
            fetch3: ctrl.we.irWrite = 1'b1;
            decode1: begin // branch target into aluOut
                ctrl.aluSrcB        = srcBImm;
                ctrl.aluOp          = aluAdd;
                ctrl.we.aluOutWrite = 1'b1;
            end
            decode2: ctrl.we.abWrite = 1'b1;
            execute: begin
                ctrl.aluOp   = aluOp;
                ctrl.aluSrcA = (latchedClass == clsJumpLink) ? srcAPc : srcARegA;
                case (latchedClass)
                    clsAluReg: ctrl.we.aluOutWrite = 1'b1;
                    clsAluImm, clsAluImmNoOvf, clsLoad, clsStore: begin
                        ctrl.aluSrcB        = srcBImm;
                        ctrl.we.aluOutWrite = 1'b1;
                    end
                    clsSltImm: begin
                        ctrl.aluSrcB     = srcBImm;
                        ctrl.memToReg    = wbCompare;
                        ctrl.we.regWrite = 1'b1;
                    end
                    clsLui: begin
                        ctrl.memToReg    = wbUpperImm;
                        ctrl.we.regWrite = 1'b1;
                    end
                    clsJr:   ctrl.we.pcWrite = 1'b1; // rs passed through the alu
                    clsJump: begin
                        ctrl.pcSrc      = pcJumpTarget;
                        ctrl.we.pcWrite = 1'b1;
                    end
                    clsJumpLink: ctrl.we.aluOutWrite = 1'b1; // pc saved for ra
                    default: ctrl.aluSrcB = srcBRegB; // branches compare rs, rt
                endcase
            end
            aluToRd: begin
                ctrl.aluOp       = aluOpQ;
                ctrl.aluSrcA     = srcARegA;
                ctrl.regDst      = dstRd;
                ctrl.memToReg    = (aluOpQ == aluCompare) ? wbCompare : wbAluOut;
                ctrl.we.regWrite = !ovfTrap;
            end
            aluToRt: ctrl.we.regWrite = !ovfTrap;
            memAddr, memWait: ctrl.iorD = addrAluOut;
            loadWrite: begin
                ctrl.iorD        = addrAluOut;
                ctrl.memToReg    = wbMemData;
                ctrl.we.regWrite = 1'b1;
            end
            storeWrite: begin
                ctrl.iorD        = addrAluOut;
                ctrl.we.memWrite = 1'b1;
            end
            branchResolve: begin
                ctrl.aluSrcA    = srcARegA;
                ctrl.aluOp      = aluCompare;
                ctrl.pcSrc      = pcBranchTarget;
                ctrl.we.pcWrite = branchTaken;
            end
            jalLink: begin
                ctrl.regDst      = dstRa;
                ctrl.we.regWrite = 1'b1;
            end
            jalJump: begin
                ctrl.pcSrc      = pcJumpTarget;
                ctrl.we.pcWrite = 1'b1;
            end
            excSave: begin // epc gets pc - 4
                ctrl.aluSrcB     = srcBFour;
                ctrl.aluOp       = aluSub;
                ctrl.we.epcWrite = 1'b1;
            end
            excVector, excWait: ctrl.iorD = excVec; // held while memory answers
            excJump: begin
                ctrl.pcSrc      = pcExcHandler;
                ctrl.we.pcWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) !(ctrl.we.memWrite && ctrl.we.regWrite))
        else $error("controlWordGen: memWrite and regWrite together");

    assert property (@(posedge clk) disable iff (reset) (state == memWait) |-> !ctrl.we.pcWrite)
        else $error("controlWordGen: pcWrite during memWait");

endmodule

// File: design/ctrlUnit.sv
`timescale 1ns/1ps

module ctrlUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::instrFields_t instr,
    input  ctrlPkg::aluFlags_t    flags,
    output ctrlPkg::ctrlWord_t    ctrl
);
    import ctrlPkg::*;

    instrClass_t instrClass;
    instrClass_t latchedClass;
    aluOp_t      aluOp;
    ctrlState_t  state;

    instrDecoder decoder_i (
        .instr      (instr),
        .instrClass (instrClass),
        .aluOp      (aluOp)
    );

    controlFsm fsm_i (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .flags        (flags),
        .state        (state),
        .latchedClass (latchedClass)
    );

    controlWordGen wordGen_i (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .latchedClass (latchedClass),
        .aluOp        (aluOp),
        .flags        (flags),
        .ctrl         (ctrl)
    );

endmodule

// File: test/ctrlChecks.svh
`ifndef CTRL_CHECKS_SVH
`define CTRL_CHECKS_SVH

task automatic checkWrites(input string what, input writeEnables_t exp);
    if (ctrl.we !== exp) begin
        valueErrors++;
        $display("error: ctrl.we in %s expected %h got %h", what, exp, ctrl.we);
    end
endtask

task automatic checkAluOp(input string what, input aluOp_t exp);
    if (ctrl.aluOp !== exp) begin
        valueErrors++;
        $display("error: ctrl.aluOp in %s expected %h got %h", what, exp, ctrl.aluOp);
    end
endtask

// all mux selects of the control word
task automatic checkSelects(input string what, input ctrlWord_t exp);
    logic [10:0] want;
    logic [10:0] got;
    want = {exp.regDst, exp.memToReg, exp.pcSrc, exp.iorD, exp.aluSrcA, exp.aluSrcB};
    got  = {ctrl.regDst, ctrl.memToReg, ctrl.pcSrc, ctrl.iorD, ctrl.aluSrcA, ctrl.aluSrcB};
    if (got !== want) begin
        valueErrors++;
        $display("error: ctrl selects in %s expected %h got %h", what, want, got);
    end
endtask

function automatic ctrlWord_t selectWord(input regDstSel_t rd, input memToRegSel_t wb,
                                         input pcSrcSel_t pc, input iorDSel_t addr,
                                         input aluSrcASel_t srcA, input aluSrcBSel_t srcB);
    ctrlWord_t w;
    w          = '0;
    w.regDst   = rd;
    w.memToReg = wb;
    w.pcSrc    = pc;
    w.iorD     = addr;
    w.aluSrcA  = srcA;
    w.aluSrcB  = srcB;
    return w;
endfunction

task automatic nextCycle();
    @(negedge clk);
endtask

// drive the instruction, then wait for the irWrite pulse
task automatic startInstr(input opcode_t op, input funct_t fn, input logic ovf, input logic eq);
    instr.opcode   = op;
    instr.funct    = fn;
    flags.overflow = ovf;
    flags.zero     = eq;
    flags.equal    = eq;
    fetchCycles    = 0;
    do begin
        @(negedge clk);
        fetchCycles++;
    end while (!ctrl.we.irWrite && fetchCycles < fetchTimeout);
    if (!ctrl.we.irWrite) begin
        timeoutErrors++;
        $display("timeout: no irWrite within %0d cycles for opcode %h", fetchTimeout, op);
    end
endtask

task automatic decodeSteps();
    checkWrites("fetch3", weIr);
    nextCycle();
    checkWrites("decode1", weAluOut);
    nextCycle();
    checkWrites("decode2", weAb);
    nextCycle(); // now in execute
endtask

task automatic finishStep();
    nextCycle();
    checkWrites("finish", weNone);
endtask

// entered with the unit in excSave
task automatic exceptionSequence(input iorDSel_t vec);
    checkWrites("excSave", weEpc);
    checkAluOp("excSave", aluSub);
    checkSelects("excSave",
                 selectWord(dstRt, wbAluOut, pcAluResult, addrPc, srcAPc, srcBFour));
    repeat (memWaitN + 1) begin // excVector, then N wait cycles
        nextCycle();
        checkWrites("excVector", weNone);
        checkSelects("excVector",
                     selectWord(dstRt, wbAluOut, pcAluResult, vec, srcAPc, srcBRegB));
    end
    nextCycle();
    checkWrites("excJump", wePc);
    checkSelects("excJump",
                 selectWord(dstRt, wbAluOut, pcExcHandler, addrPc, srcAPc, srcBRegB));
    finishStep();
endtask

task automatic resetSequence();
    repeat (8) begin
        @(negedge clk);
        checkWrites("reset", weNone);
    end
    reset = 1'b0;
    checkWrites("first cycle after reset", weNone);
    jumpDirect();
    if (fetchCycles != 2) begin
        valueErrors++;
        $display("error: fetchCycles after reset expected %h got %h", 2, fetchCycles);
    end
endtask

task automatic aluRegister(input funct_t fn, input aluOp_t op, input memToRegSel_t wb,
                           input logic ovf);
    logic trap;
    trap = ovf && (fn == addOp || fn == subOp); // and, slt never trap
    startInstr(rType, fn, ovf, 1'b0);
    decodeSteps();
    checkAluOp("execute", op);
    checkWrites("execute", weAluOut);
    nextCycle();
    checkAluOp("aluToRd", op);
    if (trap) begin
        checkWrites("aluToRd overflow", weNone);
        nextCycle();
        exceptionSequence(addrVecOverflow);
    end else begin
        checkWrites("aluToRd", weReg);
        checkSelects("aluToRd",
                     selectWord(dstRd, wb, pcAluResult, addrPc, srcARegA, srcBRegB));
        finishStep();
    end
endtask

task automatic aluImmediate(input opcode_t op, input logic ovf);
    logic trap;
    trap = ovf && (op == addi);
    startInstr(op, '0, ovf, 1'b0);
    decodeSteps();
    checkAluOp("execute", aluAdd);
    checkWrites("execute", weAluOut);
    nextCycle();
    if (trap) begin
        checkWrites("aluToRt overflow", weNone);
        nextCycle();
        exceptionSequence(addrVecOverflow);
    end else begin
        checkWrites("aluToRt", weReg);
        checkSelects("aluToRt",
                     selectWord(dstRt, wbAluOut, pcAluResult, addrPc, srcAPc, srcBRegB));
        finishStep();
    end
endtask

// slti and lui write back in execute
task automatic immediateWrite(input opcode_t op, input memToRegSel_t wb);
    aluSrcBSel_t srcB;
    srcB = (op == slti) ? srcBImm : srcBRegB; // slti compares rs with the immediate
    startInstr(op, '0, 1'b0, 1'b0);
    decodeSteps();
    checkWrites("execute", weReg);
    checkSelects("execute", selectWord(dstRt, wb, pcAluResult, addrPc, srcARegA, srcB));
    if (op == slti) begin
        checkAluOp("execute", aluCompare);
    end
    finishStep();
endtask

task automatic illegalInstr(input opcode_t op, input funct_t fn);
    startInstr(op, fn, 1'b0, 1'b0);
    decodeSteps();
    checkWrites("execute", weNone);
    nextCycle();
    exceptionSequence(addrVecIllegal);
endtask

task automatic memoryAccess(input opcode_t op);
    startInstr(op, '0, 1'b0, 1'b0);
    decodeSteps();
    checkAluOp("execute", aluAdd);
    repeat (memWaitN + 1) begin // memAddr, then N wait cycles
        nextCycle();
        checkWrites("memAddr", weNone);
        checkSelects("memAddr",
                     selectWord(dstRt, wbAluOut, pcAluResult, addrAluOut, srcAPc, srcBRegB));
    end
    nextCycle();
    if (op == lw) begin
        checkWrites("loadWrite", weReg);
        checkSelects("loadWrite",
                     selectWord(dstRt, wbMemData, pcAluResult, addrAluOut, srcAPc, srcBRegB));
    end else begin
        checkWrites("storeWrite", weMem);
        checkSelects("storeWrite",
                     selectWord(dstRt, wbAluOut, pcAluResult, addrAluOut, srcAPc, srcBRegB));
    end
    finishStep();
endtask

task automatic branchDecision(input opcode_t op, input logic eq);
    logic taken;
    taken = (op == beq) ? eq : !eq;
    startInstr(op, '0, 1'b0, eq);
    decodeSteps();
    checkAluOp("execute", aluCompare);
    checkWrites("execute", weNone);
    nextCycle();
    checkWrites("branchResolve", taken ? wePc : weNone);
    checkSelects("branchResolve",
                 selectWord(dstRt, wbAluOut, pcBranchTarget, addrPc, srcARegA, srcBRegB));
    finishStep();
endtask

task automatic jumpDirect();
    startInstr(j, '0, 1'b0, 1'b0);
    decodeSteps();
    checkWrites("execute", wePc);
    checkSelects("execute",
                 selectWord(dstRt, wbAluOut, pcJumpTarget, addrPc, srcARegA, srcBRegB));
    finishStep();
endtask

task automatic jumpAndLink();
    startInstr(jal, '0, 1'b0, 1'b0);
    decodeSteps();
    nextCycle();
    checkWrites("jalLink", weReg);
    checkSelects("jalLink",
                 selectWord(dstRa, wbAluOut, pcAluResult, addrPc, srcAPc, srcBRegB));
    nextCycle();
    checkWrites("jalJump", wePc);
    checkSelects("jalJump",
                 selectWord(dstRt, wbAluOut, pcJumpTarget, addrPc, srcAPc, srcBRegB));
    finishStep();
endtask

task automatic jumpRegister();
    startInstr(rType, jrOp, 1'b0, 1'b0);
    decodeSteps();
    checkWrites("execute", wePc);
    checkSelects("execute",
                 selectWord(dstRt, wbAluOut, pcAluResult, addrPc, srcARegA, srcBRegB));
    finishStep();
endtask

`endif

// File: test/tb_ctrlUnit.sv
`timescale 1ns/1ps
`include "ctrl_config.svh"

module tb_ctrlUnit;
    import ctrlPkg::*;

    localparam int memWaitN     = `MEM_WAIT_CYCLES;
    localparam int fetchTimeout = 10;

    // single enables, in writeEnables_t field order
    localparam writeEnables_t weNone   = 7'b0000000;
    localparam writeEnables_t weMem    = 7'b1000000;
    localparam writeEnables_t wePc     = 7'b0100000;
    localparam writeEnables_t weIr     = 7'b0010000;
    localparam writeEnables_t weReg    = 7'b0001000;
    localparam writeEnables_t weAb     = 7'b0000100;
    localparam writeEnables_t weAluOut = 7'b0000010;
    localparam writeEnables_t weEpc    = 7'b0000001;

    logic         clk;
    logic         reset;
    instrFields_t instr;
    aluFlags_t    flags;
    ctrlWord_t    ctrl;

    int valueErrors;
    int timeoutErrors;
    int fetchCycles; // falling edges from drive to irWrite

    ctrlUnit dut_i (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic endRun();
        $display("%0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    `include "ctrlChecks.svh"

    initial begin
        reset         = 1'b1;
        instr         = '0;
        flags         = '0;
        valueErrors   = 0;
        timeoutErrors = 0;
        fetchCycles   = 0;

        resetSequence();

        aluRegister(addOp, aluAdd, wbAluOut, 1'b0);
        aluRegister(subOp, aluSub, wbAluOut, 1'b0);
        aluRegister(andOp, aluAnd, wbAluOut, 1'b0);
        aluRegister(sltOp, aluCompare, wbCompare, 1'b0);
        aluImmediate(addi, 1'b0);
        aluImmediate(addiu, 1'b1); // no overflow check on addiu
        immediateWrite(slti, wbCompare);
        immediateWrite(lui, wbUpperImm);

        // overflow traps
        aluRegister(addOp, aluAdd, wbAluOut, 1'b1);
        aluRegister(subOp, aluSub, wbAluOut, 1'b1);
        aluImmediate(addi, 1'b1);

        illegalInstr(6'h3f, 6'h00);
        illegalInstr(rType, 6'h3f); // unknown funct

        memoryAccess(lw);
        memoryAccess(sw);

        branchDecision(beq, 1'b0);
        branchDecision(beq, 1'b1);
        branchDecision(bne, 1'b0);
        branchDecision(bne, 1'b1);
        jumpDirect();
        jumpAndLink();
        jumpRegister();

        endRun();
    end

endmodule

// File: src.f
+incdir+design
+incdir+test
design/ctrlPkg.sv
design/instrDecoder.sv
design/controlFsm.sv
design/controlWordGen.sv
design/ctrlUnit.sv
test/tb_ctrlUnit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ctrlUnit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
